/* hdl/cache_geom_pkg.sv */
package cache_geom_pkg;

  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = WORD_W * LINE_WORDS;  // 128
  localparam int OFFSET_W   = 4;                     // byte offset within a line

  // set count and tag width come from num_sets in each module

  typedef enum logic [2:0] {
    idle,
    lookup,
    write_back,
    refill,
    respond
  } cache_state_e;

endpackage

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

  import cache_geom_pkg::*;

  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;  // 28

  localparam int DEFAULT_MEM_LATENCY = 4;

  typedef enum logic [1:0] {
    mem_nop,
    mem_read,
    mem_write
  } mem_op_e;

endpackage

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int num_sets = 16,
  localparam int idx_w = $clog2(num_sets),
  localparam int tag_w = ADDR_W - OFFSET_W - idx_w
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   is_input_valid,
  input  logic [ADDR_W-1:0]      addr,
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  logic [WORD_W-1:0]      din,
  input  logic                   hit,
  input  logic                   victim_dirty,
  input  logic [tag_w-1:0]       victim_tag,
  input  logic                   mem_done,
  output logic                   is_ready,
  output logic                   is_output_valid,
  output logic                   is_hit,
  output logic [ADDR_W-1:0]      req_addr,
  output logic [WORD_W-1:0]      req_wdata,
  output logic                   set_line,
  output logic                   mark_dirty,
  output logic                   word_we,
  output logic                   line_we,
  output logic                   mem_req,
  output mem_op_e                mem_op,
  output logic [LINE_ADDR_W-1:0] mem_addr
);

  cache_state_e state;
  cache_state_e next_state;
  logic         accept;
  logic         req_write;
  logic         hit_r;      // lookup result, held through the miss
  logic [idx_w-1:0] req_idx;

  assign accept  = is_ready && is_input_valid && (mem_read || mem_write);
  assign req_idx = req_addr[OFFSET_W +: idx_w];

  always_comb begin
    next_state = state;
    case (state)
      idle:       if (accept) next_state = lookup;
      lookup: begin
        if (hit) begin
          next_state = idle;
        end else if (victim_dirty) begin
          next_state = write_back;
        end else begin
          next_state = refill;
        end
      end
      write_back: if (mem_done) next_state = refill;
      refill:     if (mem_done) next_state = respond;
      respond:    next_state = idle;
      default:    next_state = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= idle;
      req_write <= 1'b0;
      hit_r     <= 1'b0;
    end else begin
      state <= next_state;
      if (accept) req_write <= mem_write;
      if (state == lookup) hit_r <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= addr;
      req_wdata <= din;
    end
  end

  assign is_ready        = (state == idle);
  assign is_output_valid = (state == lookup && hit) || (state == respond);
  assign is_hit          = (state == lookup) ? hit : hit_r;

  // write hit updates at end of lookup, write miss merges in respond
  assign word_we    = req_write && ((state == lookup && hit) || state == respond);
  assign mark_dirty = word_we;
  assign line_we    = (state == refill) && mem_done;
  assign set_line   = line_we;

  always_comb begin
    mem_req  = 1'b0;
    mem_op   = mem_nop;
    mem_addr = req_addr[ADDR_W-1:OFFSET_W];
    if (state == lookup && !hit) begin
      mem_req = 1'b1;
      if (victim_dirty) begin
        mem_op   = mem_bus_pkg::mem_write;
        mem_addr = {victim_tag, req_idx};  // victim line address
      end else begin
        mem_op = mem_bus_pkg::mem_read;
      end
    end else if (state == write_back && mem_done) begin
      mem_req = 1'b1;  // refill follows the write-back at once
      mem_op  = mem_bus_pkg::mem_read;
    end
  end

  // memory answers only while a transfer is awaited
  a_done_when_waiting : assert property (
    @(posedge clk) disable iff (!rst_n)
      mem_done |-> (state == write_back || state == refill));

endmodule

/* hdl/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store
  import cache_geom_pkg::*;
#(
  parameter int num_sets = 16,
  localparam int idx_w = $clog2(num_sets),
  localparam int tag_w = ADDR_W - OFFSET_W - idx_w
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] addr,
  input  logic              set_line,
  input  logic              mark_dirty,
  output logic              hit,
  output logic              victim_dirty,
  output logic [tag_w-1:0]  victim_tag
);

  logic [tag_w-1:0]    tags [num_sets];
  logic [num_sets-1:0] valid;
  logic [num_sets-1:0] dirty;
  logic [idx_w-1:0]    idx;
  logic [tag_w-1:0]    addr_tag;

  assign idx      = addr[OFFSET_W +: idx_w];
  assign addr_tag = addr[ADDR_W-1 -: tag_w];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
      dirty <= '0;
    end else if (set_line) begin
      valid[idx] <= 1'b1;
      dirty[idx] <= 1'b0;  // fresh line from memory
    end else if (mark_dirty) begin
      dirty[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (set_line) tags[idx] <= addr_tag;
  end

  assign victim_tag   = tags[idx];
  assign hit          = valid[idx] && (tags[idx] == addr_tag);
  assign victim_dirty = valid[idx] && dirty[idx];

  a_no_set_and_dirty : assert property (
    @(posedge clk) disable iff (!rst_n) !(set_line && mark_dirty));

endmodule

/* hdl/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store
  import cache_geom_pkg::*;
#(
  parameter int num_sets = 16,
  localparam int idx_w = $clog2(num_sets),
  localparam int sel_w = $clog2(LINE_WORDS)
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] addr,
  input  logic              word_we,
  input  logic              line_we,
  input  logic [WORD_W-1:0] wdata,
  input  logic [LINE_W-1:0] line_in,
  output logic [WORD_W-1:0] rd_word,
  output logic [LINE_W-1:0] victim_line
);

  logic [LINE_W-1:0] lines [num_sets];
  logic [idx_w-1:0]  idx;
  logic [sel_w-1:0]  word_sel;

  assign idx      = addr[OFFSET_W +: idx_w];
  assign word_sel = addr[OFFSET_W-1 -: sel_w];  // word offset above byte bits

  always_ff @(posedge clk) begin
    if (line_we) begin
      lines[idx] <= line_in;
    end else if (word_we) begin
      lines[idx][word_sel*WORD_W +: WORD_W] <= wdata;
    end
  end

  assign victim_line = lines[idx];
  assign rd_word     = victim_line[word_sel*WORD_W +: WORD_W];

  a_one_write : assert property (
    @(posedge clk) !(word_we && line_we));

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ps

module data_memory
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int mem_latency = DEFAULT_MEM_LATENCY,
  parameter int mem_lines   = 256,
  localparam int line_idx_w = $clog2(mem_lines),
  localparam int cnt_w      = $clog2(mem_latency + 1)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   mem_req,
  input  mem_op_e                mem_op,
  input  logic [LINE_ADDR_W-1:0] mem_addr,
  input  logic [LINE_W-1:0]      mem_wdata,
  output logic                   mem_done,
  output logic [LINE_W-1:0]      mem_rdata
);

  logic [LINE_W-1:0]     mem_array [mem_lines];
  logic [line_idx_w-1:0] line_idx;
  logic [cnt_w-1:0]      cnt;

  assign line_idx = mem_addr[line_idx_w-1:0];

  // every word holds its own byte address at start
  initial begin
    for (int i = 0; i < mem_lines; i++) begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        mem_array[i][w*WORD_W +: WORD_W] = WORD_W'((i << OFFSET_W) + w * (WORD_W / 8));
      end
    end
  end

  always @(posedge clk) begin
    if (mem_req && mem_op == mem_write) mem_array[line_idx] <= mem_wdata;
    if (mem_req && mem_op == mem_read) mem_rdata <= mem_array[line_idx];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (mem_req) begin
      cnt <= cnt_w'(mem_latency);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign mem_done = (cnt == cnt_w'(1));

  // a new request may land in the done cycle
  a_no_overlap : assert property (
    @(posedge clk) disable iff (!rst_n) mem_req |-> (cnt == '0 || mem_done));

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/1ps

module cache_top
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int num_sets    = 16,
  parameter int mem_latency = DEFAULT_MEM_LATENCY,
  parameter int mem_lines   = 256,
  localparam int tag_w = ADDR_W - OFFSET_W - $clog2(num_sets)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              is_input_valid,
  input  logic [ADDR_W-1:0] addr,
  input  logic              mem_read,
  input  logic              mem_write,
  input  logic [WORD_W-1:0] din,
  output logic              is_ready,
  output logic              is_output_valid,
  output logic [WORD_W-1:0] dout,
  output logic              is_hit
);

  logic [ADDR_W-1:0]      req_addr;
  logic [WORD_W-1:0]      req_wdata;
  logic                   hit;
  logic                   victim_dirty;
  logic [tag_w-1:0]       victim_tag;
  logic                   set_line;
  logic                   mark_dirty;
  logic                   word_we;
  logic                   line_we;
  logic [LINE_W-1:0]      victim_line;
  logic                   mem_req;
  mem_op_e                mem_op;
  logic [LINE_ADDR_W-1:0] mem_addr;
  logic                   mem_done;
  logic [LINE_W-1:0]      mem_rdata;

  cache_ctrl #(.num_sets(num_sets)) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .is_input_valid(is_input_valid), .addr(addr),
    .mem_read(mem_read), .mem_write(mem_write), .din(din),
    .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .mem_done(mem_done),
    .is_ready(is_ready), .is_output_valid(is_output_valid), .is_hit(is_hit),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .set_line(set_line), .mark_dirty(mark_dirty),
    .word_we(word_we), .line_we(line_we),
    .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr)
  );

  cache_tag_store #(.num_sets(num_sets)) u_tags (
    .clk(clk), .rst_n(rst_n), .addr(req_addr),
    .set_line(set_line), .mark_dirty(mark_dirty),
    .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
  );

  cache_data_store #(.num_sets(num_sets)) u_data (
    .clk(clk), .addr(req_addr),
    .word_we(word_we), .line_we(line_we),
    .wdata(req_wdata), .line_in(mem_rdata),
    .rd_word(dout), .victim_line(victim_line)
  );

  data_memory #(.mem_latency(mem_latency), .mem_lines(mem_lines)) u_mem (
    .clk(clk), .rst_n(rst_n),
    .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
    .mem_wdata(victim_line),  // only a write-back stores data
    .mem_done(mem_done), .mem_rdata(mem_rdata)
  );

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
  import cache_geom_pkg::*;
();

  localparam int num_sets    = 16;
  localparam int mem_latency = 4;
  localparam int mem_lines   = 256;
  localparam int clk_period  = 100;
  localparam int drive_delay = 5;

  logic              clk;
  logic              rst_n;
  logic              is_input_valid;
  logic [ADDR_W-1:0] addr;
  logic              mem_read;
  logic              mem_write;
  logic [WORD_W-1:0] din;
  logic              is_ready;
  logic              is_output_valid;
  logic [WORD_W-1:0] dout;
  logic              is_hit;

  logic              op_q[$];     // 1 for a write
  logic [ADDR_W-1:0] addr_q[$];
  logic [WORD_W-1:0] wdata_q[$];
  logic [WORD_W-1:0] rdata_q[$];
  logic              hit_q[$];
  string             name_q[$];

  bit loaded;
  int test_err;
  int pass_cnt;
  int fail_cnt;

  cache_top #(
    .num_sets(num_sets),
    .mem_latency(mem_latency),
    .mem_lines(mem_lines)
  ) u_dut (
    .clk(clk), .rst_n(rst_n),
    .is_input_valid(is_input_valid), .addr(addr),
    .mem_read(mem_read), .mem_write(mem_write), .din(din),
    .is_ready(is_ready), .is_output_valid(is_output_valid),
    .dout(dout), .is_hit(is_hit)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  task automatic load_stimulus();
    int fd;
    int n;
    int c;
    string tok;
    string nm;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] h;
    fd = $fopen("verification/cache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/cache_stimulus.txt");
      fail_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %s", tok);
      if (n != 1) break;
      if (tok == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);  // rest of comment line
        continue;
      end
      n = $fscanf(fd, " %h %h %h %h %s", a, wd, rd, h, nm);
      if (n != 5 || (tok != "r" && tok != "w")) begin
        $display("malformed stimulus record starting with %s", tok);
        fail_cnt++;
        break;
      end
      op_q.push_back(tok == "w");
      addr_q.push_back(a);
      wdata_q.push_back(wd);
      rdata_q.push_back(rd);
      hit_q.push_back(h[0]);
      name_q.push_back(nm);
    end
    $fclose(fd);
  endtask

  task automatic check(input string test, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s %s: expected %h, actual %h", test, what, expected, actual);
      test_err++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic finish_test(input string test);
    if (test_err == 0) begin
      $display("%-18s ok", test);
      pass_cnt++;
    end else begin
      $display("%-18s failed", test);
      fail_cnt++;
    end
    test_err = 0;
  endtask

  task automatic run_access(input int i);
    int cycles;
    logic [WORD_W-1:0] data_seen;
    logic hit_seen;
    addr           = addr_q[i];
    din            = wdata_q[i];
    mem_write      = op_q[i];
    mem_read       = !op_q[i];
    is_input_valid = 1'b1;
    while (!is_ready) next_cycle();  // request held until the cache is idle
    next_cycle();  // accepted at this edge
    is_input_valid = 1'b0;
    mem_read       = 1'b0;
    mem_write      = 1'b0;
    cycles         = 1;
    while (!is_output_valid) begin
      check(name_q[i], "is_ready", 32'd0, 32'(is_ready));
      next_cycle();
      cycles++;
    end
    data_seen = dout;
    hit_seen  = is_hit;
    check(name_q[i], "is_ready", 32'd0, 32'(is_ready));
    check(name_q[i], "hit", 32'(hit_q[i]), 32'(hit_seen));
    if (!op_q[i]) check(name_q[i], "data", rdata_q[i], data_seen);
    if (hit_q[i]) check(name_q[i], "hit latency", 32'd1, cycles);
    next_cycle();
    check(name_q[i], "is_ready", 32'd1, 32'(is_ready));
    finish_test(name_q[i]);
  endtask

  initial begin
    rst_n          = 1'b0;
    is_input_valid = 1'b0;
    addr           = '0;
    mem_read       = 1'b0;
    mem_write      = 1'b0;
    din            = '0;
    test_err       = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    load_stimulus();
    loaded = 1'b1;
    if (addr_q.size() == 0) begin
      $display("no stimulus records were loaded");
      fail_cnt++;
    end
    repeat (3) @(posedge clk);
    #drive_delay rst_n = 1'b1;
    next_cycle();
    check("reset", "is_ready", 32'd1, 32'(is_ready));
    check("reset", "is_output_valid", 32'd0, 32'(is_output_valid));
    finish_test("reset");
    foreach (addr_q[i]) run_access(i);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // worst case per access is a dirty miss plus handshake cycles
  initial begin
    int limit;
    wait (loaded);
    limit = (addr_q.size() * (2 * mem_latency + 6) + 8) * clk_period;
    #(limit);
    $display("timed out after %0d ns with an access still unfinished", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verification/cache_stimulus.txt */
# op addr wdata expect_rdata expect_hit name
# op is r or w, values in hex, expect_rdata unused for writes
r 00000120 00000000 00000120 0 cold_read
r 00000124 00000000 00000124 1 line_hit_a
r 0000012c 00000000 0000012c 1 line_hit_b
w 00000128 deadbeef 00000000 1 write_hit
r 00000128 00000000 deadbeef 1 read_written
r 00000220 00000000 00000220 0 evict_dirty
r 00000128 00000000 deadbeef 0 refill_written
r 00000124 00000000 00000124 1 refill_neighbour
w 00000354 12345678 00000000 0 write_miss
r 00000354 00000000 12345678 1 read_write_miss
r 00000350 00000000 00000350 1 neighbour_lo
r 0000035c 00000000 0000035c 1 neighbour_hi
r 00000458 00000000 00000458 0 evict_set5
r 00000354 00000000 12345678 0 refill_set5
r 00000358 00000000 00000358 1 refill_set5_nb
r 000000f0 00000000 000000f0 0 cold_read_f
r 00000ffc 00000000 00000ffc 0 cold_read_ff
r 000000f4 00000000 000000f4 0 reread_f
w 00000640 aaaa5555 00000000 0 write_miss_4
w 00000640 0badf00d 00000000 1 write_hit_4
r 00000640 00000000 0badf00d 1 read_set4
r 00000644 00000000 00000644 1 read_set4_nb
w 00000740 11112222 00000000 0 write_miss_dirty
r 00000640 00000000 0badf00d 0 read_back_640
r 00000740 00000000 11112222 0 read_back_740

/* build.f */
hdl/cache_geom_pkg.sv
hdl/mem_bus_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/data_memory.sv
hdl/cache_top.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_tb -f build.f -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/cache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1
